//--- sabitler_pkg.sv
package sabitler_pkg;

    localparam int VERI_BIT  = 32;             // Veri kelimesi genişliği
    localparam int ADRES_BIT = 32;             // Byte adresi genişliği
    localparam int BYTE_BIT  = 8;
    localparam int YARIM_BIT = 2 * BYTE_BIT;   // Half word genişliği
    localparam int BYTE_SAYISI = VERI_BIT / BYTE_BIT;   // Kelimedeki byte sayısı

    // Kelime içi byte konumu için adresin alt bitleri
    localparam int KAYMA_BIT = $clog2(BYTE_SAYISI);
    localparam int KELIME_ADRES_BIT = ADRES_BIT - KAYMA_BIT;

    // Erişim maskeleri
    // Erişilen byte'lar maskenin en anlamlı ucunda durur
    localparam logic [VERI_BIT-1:0] NOP_MASKE  = 32'h0000_0000;
    localparam logic [VERI_BIT-1:0] WORD_MASKE = 32'hFFFF_FFFF;
    localparam logic [VERI_BIT-1:0] EN_ANLAMLI_HALF_WORD_MASKE = 32'hFFFF_0000;
    localparam logic [VERI_BIT-1:0] EN_ANLAMLI_BYTE_MASKE      = 32'hFF00_0000;

endpackage

//--- mikroislem_pkg.sv
package mikroislem_pkg;

    localparam int UOP_BEL_BIT = 4;   // Bellek mikro-işlem kodu genişliği
    localparam int IMM_BIT     = 12;  // İşaretli ofset
    localparam int RD_BIT      = 5;   // Hedef yazmaç numarası
    localparam int BOYUT_BIT   = 2;

    // Bellek mikro-işlemleri
    typedef enum logic [UOP_BEL_BIT-1:0] {
        UOP_BEL_NOP = 4'd0,
        UOP_BEL_LW  = 4'd1,
        UOP_BEL_LH  = 4'd2,
        UOP_BEL_LHU = 4'd3,
        UOP_BEL_LB  = 4'd4,
        UOP_BEL_LBU = 4'd5,
        UOP_BEL_SW  = 4'd6,
        UOP_BEL_SH  = 4'd7,
        UOP_BEL_SB  = 4'd8
    } bel_islem_e;

    // Boyut kodu byte sayısının bir eksiği
    localparam logic [BOYUT_BIT-1:0] BOYUT_BYTE = 2'd0;
    localparam logic [BOYUT_BIT-1:0] BOYUT_HALF = 2'd1;
    localparam logic [BOYUT_BIT-1:0] BOYUT_WORD = 2'd3;

    typedef struct packed {
        bel_islem_e                        islem;
        logic [sabitler_pkg::VERI_BIT-1:0] rs1;   // Taban adres
        logic [sabitler_pkg::VERI_BIT-1:0] rs2;   // Store verisi
        logic [IMM_BIT-1:0]                imm;   // Tüketicide sign-extend edilir
        logic [RD_BIT-1:0]                 rd;
    } bellek_istek_t;

    typedef struct packed {
        logic [sabitler_pkg::VERI_BIT-1:0] veri;  // Geri yazılacak değer
        logic [RD_BIT-1:0]                 rd;
    } yukleme_sonuc_t;

    // Load için bir çevrim taşınan bilgi
    typedef struct packed {
        logic                               isaretli;  // Sign-extend
        logic [BOYUT_BIT-1:0]               boyut;
        logic [sabitler_pkg::KAYMA_BIT-1:0] kayma;     // Lane ofseti
        logic                               hizasiz;
        logic [RD_BIT-1:0]                  rd;
    } yukleme_bilgisi_t;

endpackage

//--- bellek_islem_birimi.sv
`timescale 1ns/10ps

module bellek_islem_birimi (
    // Saat ve reset yalnız çekirdek arayüzünün parçası
    // Birimin kendisi tamamen kombinezonsal
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  mikroislem_pkg::bel_islem_e            uop_buyruk_secim_i,
    input  logic [sabitler_pkg::VERI_BIT-1:0]     uop_rs1_i,      // Taban adres
    input  logic [mikroislem_pkg::IMM_BIT-1:0]    uop_imm_i,      // İşaretli ofset
    output logic [sabitler_pkg::VERI_BIT-1:0]     maske_o,
    output logic [sabitler_pkg::ADRES_BIT-1:0]    erisilecek_adres_o
);

    import sabitler_pkg::*;
    import mikroislem_pkg::*;

    logic [ADRES_BIT-1:0] imm_genis;     // Sign-extend edilmiş ofset
    logic [ADRES_BIT-1:0] hedef_adres;

    assign imm_genis   = {{(ADRES_BIT-IMM_BIT){uop_imm_i[IMM_BIT-1]}}, uop_imm_i};
    assign hedef_adres = imm_genis + uop_rs1_i;

    always_comb begin
        // Tanımsız kodlar NOP gibi davranır
        maske_o            = NOP_MASKE;
        erisilecek_adres_o = '0;
        case (uop_buyruk_secim_i)
            UOP_BEL_NOP: begin
                maske_o            = NOP_MASKE;   // Ne load ne store
                erisilecek_adres_o = '0;
            end
            // 32 bit erişim
            UOP_BEL_LW,
            UOP_BEL_SW: begin
                maske_o            = WORD_MASKE;
                erisilecek_adres_o = hedef_adres;
            end
            // 16 bit erişim
            // LH ile LHU farkı yükleme biriminde
            UOP_BEL_LH,
            UOP_BEL_LHU,
            UOP_BEL_SH: begin
                maske_o            = EN_ANLAMLI_HALF_WORD_MASKE;
                erisilecek_adres_o = hedef_adres;
            end
            // 8 bit erişim
            UOP_BEL_LB,
            UOP_BEL_LBU,
            UOP_BEL_SB: begin
                maske_o            = EN_ANLAMLI_BYTE_MASKE;   // En üst byte
                erisilecek_adres_o = hedef_adres;
            end
            default: begin
                maske_o            = NOP_MASKE;
                erisilecek_adres_o = '0;
            end
        endcase
    end

endmodule

//--- hizalama_birimi.sv
`timescale 1ns/10ps

module hizalama_birimi (
    input  mikroislem_pkg::bel_islem_e                islem_i,
    input  logic [sabitler_pkg::ADRES_BIT-1:0]        adres_i,
    input  logic [sabitler_pkg::VERI_BIT-1:0]         maske_i,
    input  logic [sabitler_pkg::VERI_BIT-1:0]         rs2_i,
    input  logic [mikroislem_pkg::RD_BIT-1:0]         rd_i,
    output logic [sabitler_pkg::BYTE_SAYISI-1:0]      yaz_strobe_o,
    output logic [sabitler_pkg::VERI_BIT-1:0]         yaz_veri_o,
    output logic [sabitler_pkg::KELIME_ADRES_BIT-1:0] kelime_adres_o,
    output logic                                      oku_o,
    output mikroislem_pkg::yukleme_bilgisi_t          bilgi_o
);

    import sabitler_pkg::*;
    import mikroislem_pkg::*;

    logic [BYTE_SAYISI-1:0]   desen;         // Alt lane'lere indirilmiş byte deseni
    logic [KAYMA_BIT:0]       bayt_sayisi;   // 0..4
    logic [KAYMA_BIT-1:0]     kayma;
    logic [2*BYTE_SAYISI-1:0] yerlesik;      // Taşan lane'ler üst yarıda
    logic [VERI_BIT-1:0]      veri_maskesi;
    logic                     hizasiz;
    logic                     yukleme_islemi;
    logic                     depolama_islemi;

    assign kayma = adres_i[KAYMA_BIT-1:0];

    // Maskenin en anlamlı byte'ı lane 0'a gelir ve desen ters çevrilerek iner
    always_comb begin
        bayt_sayisi = '0;
        for (int i = 0; i < BYTE_SAYISI; i++) begin
            desen[i]    = |maske_i[VERI_BIT-1-i*BYTE_BIT -: BYTE_BIT];
            bayt_sayisi = bayt_sayisi + desen[i];
            veri_maskesi[i*BYTE_BIT +: BYTE_BIT] = {BYTE_BIT{desen[i]}};
        end
    end

    // Desen adres ofseti kadar kaydırılır
    assign yerlesik = {{BYTE_SAYISI{1'b0}}, desen} << kayma;
    assign hizasiz  = |yerlesik[2*BYTE_SAYISI-1:BYTE_SAYISI];   // Kelime sınırı aşıldı

    assign yukleme_islemi  = islem_i inside {UOP_BEL_LW, UOP_BEL_LH, UOP_BEL_LHU,
                                              UOP_BEL_LB, UOP_BEL_LBU};
    assign depolama_islemi = islem_i inside {UOP_BEL_SW, UOP_BEL_SH, UOP_BEL_SB};

    // Hizasız store hiçbir byte yazmaz
    assign yaz_strobe_o = (depolama_islemi && !hizasiz) ? yerlesik[BYTE_SAYISI-1:0] : '0;
    // rs2'nin alt n byte'ı 8*ofset kadar sola kayar
    assign yaz_veri_o   = (rs2_i & veri_maskesi) << {kayma, 3'b000};

    assign kelime_adres_o = adres_i[ADRES_BIT-1:KAYMA_BIT];
    assign oku_o          = yukleme_islemi && (|desen);

    always_comb begin
        bilgi_o.isaretli = islem_i inside {UOP_BEL_LH, UOP_BEL_LB};
        bilgi_o.boyut    = bayt_sayisi[BOYUT_BIT-1:0] - 2'd1;   // 4 byte 3'e sarar
        bilgi_o.kayma    = kayma;
        bilgi_o.hizasiz  = hizasiz;   // Load ve store için ortak
        bilgi_o.rd       = rd_i;
    end

endmodule

//--- veri_bellegi.sv
`timescale 1ns/10ps

module veri_bellegi #(
    parameter int DERINLIK = 256   // Kelime sayısı, ikinin kuvveti
) (
    input  logic                                      clk_i,
    input  logic [sabitler_pkg::KELIME_ADRES_BIT-1:0] kelime_adres_i,
    input  logic [sabitler_pkg::BYTE_SAYISI-1:0]      yaz_strobe_i,
    input  logic [sabitler_pkg::VERI_BIT-1:0]         yaz_veri_i,
    output logic [sabitler_pkg::VERI_BIT-1:0]         oku_veri_o
);

    import sabitler_pkg::*;

    localparam int INDIS_BIT = $clog2(DERINLIK);

    logic [VERI_BIT-1:0]  bellek [DERINLIK];
    logic [INDIS_BIT-1:0] indis;

    // Adres DERINLIK modülünde alınır ve üst bitler yok sayılır
    assign indis = kelime_adres_i[INDIS_BIT-1:0];

    always_ff @(posedge clk_i) begin
        // Her lane kendi strobe'u ile yazılır
        for (int i = 0; i < BYTE_SAYISI; i++) begin
            if (yaz_strobe_i[i]) begin
                bellek[indis][i*BYTE_BIT +: BYTE_BIT] <= yaz_veri_i[i*BYTE_BIT +: BYTE_BIT];
            end
        end
        // Okuma her çevrim kaydedilir
        // Önceki çevrimin store'u burada görünür
        oku_veri_o <= bellek[indis];
    end

endmodule

//--- yukleme_birimi.sv
`timescale 1ns/10ps

module yukleme_birimi (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              oku_i,        // Bu çevrimde load var
    input  mikroislem_pkg::yukleme_bilgisi_t  bilgi_i,
    input  logic [sabitler_pkg::VERI_BIT-1:0] oku_veri_i,   // Bellekten kayıtlı kelime
    input  logic                              hata_i,       // Hizasız store
    output logic                              sonuc_gecerli_o,
    output mikroislem_pkg::yukleme_sonuc_t    sonuc_o,
    output logic                              hizasiz_o
);

    import sabitler_pkg::*;
    import mikroislem_pkg::*;

    logic                oku_q;
    logic                hizasiz_q;
    yukleme_bilgisi_t    bilgi_q;
    logic [VERI_BIT-1:0] kaydirilmis;
    logic [VERI_BIT-1:0] yuklenen;

    // Kontrol bayrakları
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            oku_q     <= 1'b0;
            hizasiz_q <= 1'b0;
        end else begin
            oku_q     <= oku_i;
            hizasiz_q <= hata_i | (oku_i & bilgi_i.hizasiz);   // Load ya da store
        end
    end

    // Load bilgisi yalnız load çevriminde tutulur
    always_ff @(posedge clk_i) begin
        if (oku_i) begin
            bilgi_q <= bilgi_i;
        end
    end

    always_comb begin
        // İstenen byte'lar lane 0'a iner
        kaydirilmis = oku_veri_i >> {bilgi_q.kayma, 3'b000};
        case (bilgi_q.boyut)
            BOYUT_BYTE: begin
                yuklenen = {{(VERI_BIT-BYTE_BIT){bilgi_q.isaretli & kaydirilmis[BYTE_BIT-1]}},
                            kaydirilmis[BYTE_BIT-1:0]};
            end
            BOYUT_HALF: begin
                yuklenen = {{(VERI_BIT-YARIM_BIT){bilgi_q.isaretli & kaydirilmis[YARIM_BIT-1]}},
                            kaydirilmis[YARIM_BIT-1:0]};
            end
            default: begin
                yuklenen = kaydirilmis;   // BOYUT_WORD
            end
        endcase
        if (bilgi_q.hizasiz) begin
            yuklenen = '0;   // Hizasız load sıfır döner
        end
    end

    assign sonuc_o.veri    = yuklenen;
    assign sonuc_o.rd      = bilgi_q.rd;
    assign sonuc_gecerli_o = oku_q;
    assign hizasiz_o       = hizasiz_q;

endmodule

//--- bellek_asamasi.sv
`timescale 1ns/10ps

module bellek_asamasi #(
    parameter int DERINLIK = 256
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           gecerli_i,
    input  mikroislem_pkg::bellek_istek_t  istek_i,
    output logic                           sonuc_gecerli_o,
    output mikroislem_pkg::yukleme_sonuc_t sonuc_o,
    output logic                           hizasiz_o
);

    import sabitler_pkg::*;
    import mikroislem_pkg::*;

    bel_islem_e                  islem;   // Geçersiz çevrimde NOP
    logic [VERI_BIT-1:0]         maske;
    logic [ADRES_BIT-1:0]        erisilecek_adres;
    logic [BYTE_SAYISI-1:0]      yaz_strobe;
    logic [VERI_BIT-1:0]         yaz_veri;
    logic [KELIME_ADRES_BIT-1:0] kelime_adres;
    logic                        oku;
    yukleme_bilgisi_t            bilgi;
    logic [VERI_BIT-1:0]         oku_veri;
    logic                        depo_hatasi;

    // gecerli_i yalnız burada bakılır
    assign islem       = gecerli_i ? istek_i.islem : UOP_BEL_NOP;
    assign depo_hatasi = bilgi.hizasiz & ~oku;   // Hizasız olup load olmayan store

    bellek_islem_birimi u_bellek_islem_birimi (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .uop_buyruk_secim_i (islem),
        .uop_rs1_i          (istek_i.rs1),
        .uop_imm_i          (istek_i.imm),
        .maske_o            (maske),
        .erisilecek_adres_o (erisilecek_adres)
    );

    hizalama_birimi u_hizalama_birimi (
        .islem_i        (islem),
        .adres_i        (erisilecek_adres),
        .maske_i        (maske),
        .rs2_i          (istek_i.rs2),
        .rd_i           (istek_i.rd),
        .yaz_strobe_o   (yaz_strobe),
        .yaz_veri_o     (yaz_veri),
        .kelime_adres_o (kelime_adres),
        .oku_o          (oku),
        .bilgi_o        (bilgi)
    );

    veri_bellegi #(
        .DERINLIK (DERINLIK)
    ) u_veri_bellegi (
        .clk_i          (clk_i),
        .kelime_adres_i (kelime_adres),
        .yaz_strobe_i   (yaz_strobe),
        .yaz_veri_i     (yaz_veri),
        .oku_veri_o     (oku_veri)
    );

    yukleme_birimi u_yukleme_birimi (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .oku_i           (oku),
        .bilgi_i         (bilgi),
        .oku_veri_i      (oku_veri),
        .hata_i          (depo_hatasi),
        .sonuc_gecerli_o (sonuc_gecerli_o),
        .sonuc_o         (sonuc_o),
        .hizasiz_o       (hizasiz_o)
    );

endmodule

//--- tb_bellek_asamasi.sv
`timescale 1ns/10ps

module tb_bellek_asamasi;

    import sabitler_pkg::*;
    import mikroislem_pkg::*;

    localparam int DERINLIK       = 256;
    localparam int SAAT_PERIYOT   = 8;
    localparam int RESET_CEVRIM   = 16;
    localparam int MODEL_BYTE     = 1024;                       // Adresler 1024'te sarar
    localparam int ON_YUKLEME     = MODEL_BYTE / BYTE_SAYISI;   // Her kelimeye bir SW
    localparam int RASTGELE_ISTEK = 2000;
    localparam int KUYRUK_CEVRIM  = 2;
    localparam int TOPLAM_ISTEK   = ON_YUKLEME + RASTGELE_ISTEK + KUYRUK_CEVRIM;
    localparam int ZAMAN_SINIRI   = 2 * TOPLAM_ISTEK * SAAT_PERIYOT
                                    + RESET_CEVRIM * SAAT_PERIYOT;

    // Bir sonraki çevrimde beklenen çıkışlar
    typedef struct packed {
        logic                gecerli;
        logic                hizasiz;
        logic [VERI_BIT-1:0] veri;
        logic [RD_BIT-1:0]   rd;
    } beklenen_t;

    logic           clk;
    logic           rst;
    logic           gecerli;
    bellek_istek_t  istek;
    logic           sonuc_gecerli;
    yukleme_sonuc_t sonuc;
    logic           hizasiz;

    logic [7:0]         model_bellek [MODEL_BYTE];   // Byte bazlı referans bellek
    beklenen_t          bek_q [$];
    integer             tohum;
    int                 hata_sayisi;
    int                 kontrol_sayisi;
    logic [ADRES_BIT-1:0] son_rs1;   // Aynı adrese tekrar erişim için
    logic [IMM_BIT-1:0]   son_imm;

    bellek_asamasi #(
        .DERINLIK (DERINLIK)
    ) UUT (
        .clk_i           (clk),
        .rst_i           (rst),
        .gecerli_i       (gecerli),
        .istek_i         (istek),
        .sonuc_gecerli_o (sonuc_gecerli),
        .sonuc_o         (sonuc),
        .hizasiz_o       (hizasiz)
    );

    initial begin
        clk = 1'b0;
        forever #(SAAT_PERIYOT / 2) clk = ~clk;
    end

    // Erişilen byte sayısı NOP için sıfır
    function automatic int erisim_boyu(input bel_islem_e op);
        case (op)
            UOP_BEL_LW, UOP_BEL_SW:               return 4;
            UOP_BEL_LH, UOP_BEL_LHU, UOP_BEL_SH:  return 2;
            UOP_BEL_LB, UOP_BEL_LBU, UOP_BEL_SB:  return 1;
            default:                              return 0;
        endcase
    endfunction

    // Ön yükleme deseni kelime adresinin tüm bitlerine bağlı
    function automatic logic [31:0] dolgu_deseni(input logic [9:0] a);
        return {a[9:2], ~a[9:2], a[9:2] ^ 8'h5A, a[9:2] + 8'h3C};
    endfunction

    task automatic karsilastir(input string isim, input logic [31:0] gercek,
                               input logic [31:0] beklenen);
        kontrol_sayisi++;
        if (gercek !== beklenen) begin
            hata_sayisi++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, isim, gercek, beklenen);
        end
    endtask

    // Bir çevrim önce sürülen isteğin sonucu
    task automatic cikisi_denetle;
        beklenen_t bek;
        bek = '0;   // Reset süresince her şey düşük
        if (bek_q.size() != 0) begin
            bek = bek_q.pop_front();
        end
        karsilastir("sonuc_gecerli_o", sonuc_gecerli, bek.gecerli);
        karsilastir("hizasiz_o", hizasiz, bek.hizasiz);
        if (bek.gecerli) begin
            karsilastir("sonuc_o.veri", sonuc.veri, bek.veri);
            karsilastir("sonuc_o.rd", sonuc.rd, bek.rd);
        end
    endtask

    task automatic cevrim_ilerle;
        @(posedge clk);
        #1;   // Kayıtlı çıkışlar kenardan sonra kararlı
        cikisi_denetle();
    endtask

    // İsteği sürer, modeli günceller ve beklenen sonucu kuyruğa atar
    task automatic istek_sur(input logic gec, input bel_islem_e op,
                             input logic [31:0] rs1, input logic [11:0] imm,
                             input logic [31:0] rs2, input logic [4:0] rd);
        logic [31:0] adres;
        logic [9:0]  model_adres;
        int          n;
        logic        hizasiz_bek;
        logic [31:0] deger;
        beklenen_t   bek;
        adres       = rs1 + {{20{imm[11]}}, imm};
        model_adres = adres[9:0];
        n           = gec ? erisim_boyu(op) : 0;   // Geçersiz çevrim NOP sayılır
        hizasiz_bek = (n != 0) && (int'(adres[1:0]) + n > 4);   // Kelime sınırı aşılıyor
        bek         = '0;
        bek.hizasiz = hizasiz_bek;
        if (n != 0 && op inside {UOP_BEL_LW, UOP_BEL_LH, UOP_BEL_LHU,
                                 UOP_BEL_LB, UOP_BEL_LBU}) begin
            bek.gecerli = 1'b1;
            bek.rd      = rd;
            deger       = '0;
            if (!hizasiz_bek) begin
                // A'dan A+n-1'e little-endian
                for (int i = 0; i < n; i++) begin
                    deger[8*i +: 8] = model_bellek[model_adres + i];
                end
                if (op == UOP_BEL_LH) begin
                    deger = {{16{deger[15]}}, deger[15:0]};
                end
                if (op == UOP_BEL_LB) begin
                    deger = {{24{deger[7]}}, deger[7:0]};
                end
            end
            bek.veri = deger;   // Hizasız load sıfır
        end else if (n != 0 && !hizasiz_bek) begin
            for (int i = 0; i < n; i++) begin
                model_bellek[model_adres + i] = rs2[8*i +: 8];
            end
        end
        gecerli     = gec;
        istek.islem = op;
        istek.rs1   = rs1;
        istek.rs2   = rs2;
        istek.imm   = imm;
        istek.rd    = rd;
        bek_q.push_back(bek);
    endtask

    task automatic rastgele_istek;
        logic        gec;
        bel_islem_e  op;
        logic [31:0] rs1;
        logic [11:0] imm;
        logic [31:0] rs2;
        logic [4:0]  rd;
        gec = ($unsigned($random(tohum)) % 4) != 0;   // Yaklaşık yüzde 75 geçerli
        op  = bel_islem_e'($unsigned($random(tohum)) % 9);
        if ($unsigned($random(tohum)) % 4 == 0) begin
            rs1 = son_rs1;   // Store ardından aynı adrese load
            imm = son_imm;
        end else begin
            rs1 = $random(tohum);
            imm = 12'($random(tohum));
            if ($unsigned($random(tohum)) % 2 == 0) begin
                rs1[1:0] = 2'b00;   // Hizalı erişimler çoğalsın
                imm[1:0] = 2'b00;
            end
        end
        son_rs1 = rs1;
        son_imm = imm;
        rs2 = $random(tohum);
        rd  = 5'($random(tohum));
        istek_sur(gec, op, rs1, imm, rs2, rd);
    endtask

    initial begin
        tohum          = 32'h68662498;
        hata_sayisi    = 0;
        kontrol_sayisi = 0;
        son_rs1        = '0;
        son_imm        = '0;
        rst            = 1'b1;
        gecerli        = 1'b0;
        istek          = '0;

        // Reset boyunca çıkış darbeleri düşük kalmalı
        repeat (RESET_CEVRIM) cevrim_ilerle();
        rst = 1'b0;

        // Bellek resetlenmediği için önce her kelime SW ile doldurulur
        for (int w = 0; w < ON_YUKLEME; w++) begin
            istek_sur(1'b1, UOP_BEL_SW, 32'(w * 4), 12'h000,
                      dolgu_deseni(10'(w * 4)), 5'(w));
            cevrim_ilerle();
        end

        for (int k = 0; k < RASTGELE_ISTEK; k++) begin
            rastgele_istek();
            cevrim_ilerle();
        end

        // Son istekler boşalırken darbe gelmemeli
        repeat (KUYRUK_CEVRIM) begin
            istek_sur(1'b0, UOP_BEL_NOP, '0, '0, '0, '0);
            cevrim_ilerle();
        end

        $display("Checks: %0d, errors: %0d", kontrol_sayisi, hata_sayisi);
        if (hata_sayisi == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Bekçi tüm isteklerin iki katı süre bekler
    initial begin
        #(ZAMAN_SINIRI);
        $display("Timeout: the run did not finish within %0d ns, the simulation hung",
                 ZAMAN_SINIRI);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- tb.f
sabitler_pkg.sv
mikroislem_pkg.sv
bellek_islem_birimi.sv
hizalama_birimi.sv
veri_bellegi.sv
yukleme_birimi.sv
bellek_asamasi.sv
tb_bellek_asamasi.sv
